//--- source/dino_pkg.sv
package dino_pkg;

	typedef logic [8:0]  pos_x_t;   // Horizontal pixel, 320 wide screen
	typedef logic [7:0]  pos_y_t;   // Vertical pixel, 240 high screen
	typedef logic [15:0] score_t;
	typedef logic [3:0]  bcd_t;
	typedef logic [6:0]  seg7_t;    // Active low, segment a in bit 0

	typedef enum logic [1:0] {
		RUNNING,
		ASCENDING,
		DESCENDING
	} jump_state_t;

	// Screen and object geometry
	localparam int SCREEN_W = 320;
	localparam int BOX_SIZE = 32;
	localparam pos_x_t OBSTACLE_WRAP_X = pos_x_t'(SCREEN_W - BOX_SIZE);

	localparam pos_x_t DINO_X = 9'd52;
	localparam pos_y_t DINO_GROUND_Y = 8'd109;
	localparam pos_y_t JUMP_HEIGHT = 8'd60;

	localparam pos_y_t OBSTACLE_Y = 8'd114;
	localparam pos_x_t OBSTACLE_X_INIT = 9'd320;

	// Half window of the overlap test
	localparam int HITBOX_W = 20;
	localparam int HITBOX_H = 30;

	// Respawn lands somewhere in the 100 columns right of the wrap point
	localparam int RESPAWN_SPREAD = 100;
	localparam logic [15:0] LFSR_SEED = 16'hACE1;

	localparam int DUCK_TICKS = 96;   // In game ticks

	// Command bytes from the serial link
	localparam logic [7:0] CMD_JUMP = "J";
	localparam logic [7:0] CMD_DUCK = "D";

	localparam seg7_t SEG7_BLANK = 7'b1111111;

endpackage

//--- source/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
	parameter int OS_DIV = 27
) (
	input  logic       Clock,
	input  logic       rst_n,
	input  logic       rxd,
	output logic       rx_valid,
	output logic [7:0] rx_byte
);
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	typedef logic [$clog2(OS_DIV + 1) - 1:0] div_cnt_t;

	div_cnt_t  div_cnt;
	logic      os_tick;
	logic      rxd_m;
	logic      rxd_s;
	rx_state_t rx_state;
	logic [3:0] os_cnt;     // Ticks left to the next sample point
	logic [2:0] bit_cnt;
	logic [7:0] shift;

	assign os_tick = (div_cnt == div_cnt_t'(OS_DIV - 1));

	always_ff @(posedge Clock) begin
		if (!rst_n || os_tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Line idles high, so the synchronizer starts there too
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			rxd_m <= 1'b1;
			rxd_s <= 1'b1;
		end else begin
			rxd_m <= rxd;
			rxd_s <= rxd_m;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			rx_state <= RX_IDLE;
			os_cnt <= '0;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (os_tick) begin
				if (os_cnt != 4'd0) begin
					os_cnt <= os_cnt - 1'b1;
				end else begin
					case (rx_state)
						RX_IDLE: begin
							if (!rxd_s) begin
								rx_state <= RX_START;
								os_cnt <= 4'd7;   // Half a bit to mid start
							end
						end
						RX_START: begin
							// Glitch shorter than half a bit goes back to idle
							rx_state <= rxd_s ? RX_IDLE : RX_DATA;
							os_cnt <= 4'd15;
							bit_cnt <= '0;
						end
						RX_DATA: begin
							os_cnt <= 4'd15;
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == 3'd7) begin
								rx_state <= RX_STOP;
							end
						end
						default: begin
							rx_valid <= rxd_s;   // Framing error drops the byte
							rx_state <= RX_IDLE;
						end
					endcase
				end
			end
		end
	end

	// LSB arrives first
	always_ff @(posedge Clock) begin
		if (os_tick && os_cnt == 4'd0) begin
			if (rx_state == RX_DATA) begin
				shift <= {rxd_s, shift[7:1]};
			end
			if (rx_state == RX_STOP) begin
				rx_byte <= shift;
			end
		end
	end

	assert property (@(posedge Clock) disable iff (!rst_n) rx_valid |=> !rx_valid);

endmodule

//--- source/player_command.sv
`timescale 1ns/1ps

module player_command (
	input  logic       Clock,
	input  logic       rst_n,
	input  logic       key_jump_n,
	input  logic       key_duck_n,
	input  logic       rx_valid,
	input  logic [7:0] rx_byte,
	output logic       jump_cmd,
	output logic       duck_cmd
);
	// Bit 0 is the jump button, bit 1 the duck button
	logic [1:0] key_m;
	logic [1:0] key_s;
	logic [1:0] key_d;
	logic [1:0] key_pulse;
	logic       jump_byte;
	logic       duck_byte;

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			key_m <= '0;
			key_s <= '0;
			key_d <= '0;
			jump_byte <= 1'b0;
			duck_byte <= 1'b0;
		end else begin
			key_m <= ~{key_duck_n, key_jump_n};   // Pressed reads as 1
			key_s <= key_m;
			key_d <= key_s;
			jump_byte <= rx_valid && (rx_byte == dino_pkg::CMD_JUMP);
			duck_byte <= rx_valid && (rx_byte == dino_pkg::CMD_DUCK);
		end
	end

	assign key_pulse = key_s & ~key_d;   // One cycle per press

	assign jump_cmd = jump_byte | key_pulse[0];
	assign duck_cmd = duck_byte | key_pulse[1];

endmodule

//--- source/dino_motion.sv
`timescale 1ns/1ps

module dino_motion #(
	parameter int TICK_CYCLES = 524288
) (
	input  logic              Clock,
	input  logic              rst_n,
	input  logic              game_over,
	input  logic              jump_cmd,
	input  logic              duck_cmd,
	output dino_pkg::pos_y_t  dino_y,
	output logic              ducking
);
	typedef logic [$clog2(TICK_CYCLES + 1) - 1:0] tick_cnt_t;
	typedef logic [$clog2(dino_pkg::DUCK_TICKS + 1) - 1:0] duck_cnt_t;

	tick_cnt_t             tick_cnt;
	logic                  tick;
	dino_pkg::jump_state_t jump_state;
	duck_cnt_t             duck_left;   // Ticks of ducking still to go

	assign tick = (tick_cnt == tick_cnt_t'(TICK_CYCLES - 1));
	assign ducking = (duck_left != '0);

	always_ff @(posedge Clock) begin
		if (!rst_n || game_over || tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// Height moves one pixel per tick, turning at the apex
	always_ff @(posedge Clock) begin
		if (!rst_n || game_over) begin
			jump_state <= dino_pkg::RUNNING;
			dino_y <= dino_pkg::DINO_GROUND_Y;
		end else begin
			case (jump_state)
				dino_pkg::RUNNING: begin
					if (jump_cmd && !ducking) begin
						jump_state <= dino_pkg::ASCENDING;
					end
				end
				dino_pkg::ASCENDING: begin
					if (tick) begin
						dino_y <= dino_y - 1'b1;
						if (dino_y == dino_pkg::DINO_GROUND_Y - dino_pkg::JUMP_HEIGHT + 8'd1) begin
							jump_state <= dino_pkg::DESCENDING;
						end
					end
				end
				dino_pkg::DESCENDING: begin
					if (tick) begin
						dino_y <= dino_y + 1'b1;
						if (dino_y == dino_pkg::DINO_GROUND_Y - 8'd1) begin
							jump_state <= dino_pkg::RUNNING;   // Landed
						end
					end
				end
				default: jump_state <= dino_pkg::RUNNING;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (!rst_n || game_over) begin
			duck_left <= '0;
		end else if (duck_cmd && !ducking && jump_state == dino_pkg::RUNNING) begin
			duck_left <= duck_cnt_t'(dino_pkg::DUCK_TICKS);
		end else if (tick && ducking) begin
			duck_left <= duck_left - 1'b1;
		end
	end

	assert property (@(posedge Clock) disable iff (!rst_n)
		dino_y >= dino_pkg::DINO_GROUND_Y - dino_pkg::JUMP_HEIGHT &&
		dino_y <= dino_pkg::DINO_GROUND_Y);

endmodule

//--- source/obstacle_motion.sv
`timescale 1ns/1ps

module obstacle_motion #(
	parameter int TICK_CYCLES = 524288
) (
	input  logic             Clock,
	input  logic             rst_n,
	input  logic             game_over,
	input  logic             respawn,
	output dino_pkg::pos_x_t obstacle_x
);
	typedef logic [$clog2(TICK_CYCLES + 1) - 1:0] tick_cnt_t;

	tick_cnt_t   tick_cnt;
	logic        tick;
	logic [15:0] lfsr;
	logic        feedback;

	// Same divider as the dinosaur, so both move on the same edge
	assign tick = (tick_cnt == tick_cnt_t'(TICK_CYCLES - 1));

	always_ff @(posedge Clock) begin
		if (!rst_n || game_over || tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	assign feedback = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];

	always_ff @(posedge Clock) begin
		if (!rst_n || game_over) begin
			lfsr <= dino_pkg::LFSR_SEED;
		end else begin
			lfsr <= {lfsr[14:0], feedback};
		end
	end

	always_ff @(posedge Clock) begin
		if (!rst_n || game_over) begin
			obstacle_x <= dino_pkg::OBSTACLE_X_INIT;
		end else if (respawn) begin
			obstacle_x <= dino_pkg::OBSTACLE_WRAP_X +
				dino_pkg::pos_x_t'(lfsr % dino_pkg::RESPAWN_SPREAD);
		end else if (tick) begin
			if (obstacle_x <= 9'd1) begin
				obstacle_x <= dino_pkg::OBSTACLE_WRAP_X;   // Off the left edge
			end else begin
				obstacle_x <= obstacle_x - 1'b1;
			end
		end
	end

endmodule

//--- source/score_keeper.sv
`timescale 1ns/1ps

module score_keeper (
	input  logic             Clock,
	input  logic             rst_n,
	input  dino_pkg::pos_y_t dino_y,
	input  dino_pkg::pos_x_t obstacle_x,
	output logic             game_over,
	output logic             respawn,
	output dino_pkg::score_t score,
	output dino_pkg::score_t high_score
);
	logic             overlap;
	logic             overlap_d;
	logic             pass;
	dino_pkg::pos_x_t prev_x;
	dino_pkg::score_t best = '0;   // Kept across rst_n

	// Boxes overlap when both axes are within the hitbox window
	assign overlap =
		(dino_pkg::DINO_X + dino_pkg::HITBOX_W >= obstacle_x) &&
		(dino_pkg::DINO_X <= obstacle_x + dino_pkg::HITBOX_W) &&
		(dino_y + dino_pkg::HITBOX_H >= dino_pkg::OBSTACLE_Y) &&
		(dino_y <= dino_pkg::OBSTACLE_Y + dino_pkg::HITBOX_H);

	// Obstacle just moved past the dinosaur column without touching it
	assign pass = (prev_x > dino_pkg::DINO_X) && (obstacle_x <= dino_pkg::DINO_X) &&
		!overlap && !overlap_d;

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			game_over <= 1'b0;
			respawn <= 1'b0;
			score <= '0;
			prev_x <= dino_pkg::OBSTACLE_X_INIT;
			overlap_d <= 1'b0;
		end else begin
			prev_x <= obstacle_x;
			overlap_d <= overlap;
			respawn <= 1'b0;
			if (overlap) begin
				game_over <= 1'b1;   // Held until rst_n
			end
			if (pass && !game_over) begin
				score <= score + 1'b1;
				respawn <= 1'b1;
			end
		end
	end

	// Compare at the edge where game_over goes high
	always_ff @(posedge Clock) begin
		if (rst_n && overlap && !game_over && score > best) begin
			best <= score;
		end
	end

	assign high_score = best;

	assert property (@(posedge Clock) disable iff (!rst_n)
		$past(rst_n) |-> score >= $past(score));

endmodule

//--- source/score_display.sv
`timescale 1ns/1ps

module score_display (
	input  dino_pkg::score_t score,
	input  dino_pkg::score_t high_score,
	output dino_pkg::seg7_t  hex0,
	output dino_pkg::seg7_t  hex1,
	output dino_pkg::seg7_t  hex2,
	output dino_pkg::seg7_t  hex3,
	output dino_pkg::seg7_t  hex4,
	output dino_pkg::seg7_t  hex5
);
	// Decimal digit at the given place value
	function automatic dino_pkg::bcd_t digit_of(input dino_pkg::score_t value,
		input int unsigned place);
		digit_of = dino_pkg::bcd_t'((value / place) % 10);
	endfunction

	function automatic dino_pkg::seg7_t encode(input dino_pkg::bcd_t digit);
		case (digit)
			4'd0: encode = 7'b1000000;
			4'd1: encode = 7'b1111001;
			4'd2: encode = 7'b0100100;
			4'd3: encode = 7'b0110000;
			4'd4: encode = 7'b0011001;
			4'd5: encode = 7'b0010010;
			4'd6: encode = 7'b0000010;
			4'd7: encode = 7'b1111000;
			4'd8: encode = 7'b0000000;
			4'd9: encode = 7'b0010000;
			default: encode = dino_pkg::SEG7_BLANK;
		endcase
	endfunction

	assign hex0 = encode(digit_of(score, 1));
	assign hex1 = encode(digit_of(score, 10));
	assign hex2 = encode(digit_of(score, 100));
	assign hex3 = encode(digit_of(high_score, 1));   // High score on the left three
	assign hex4 = encode(digit_of(high_score, 10));
	assign hex5 = encode(digit_of(high_score, 100));

endmodule

//--- source/dino_game_top.sv
`timescale 1ns/1ps

module dino_game_top #(
	parameter int TICK_CYCLES = 524288,
	parameter int OS_DIV = 27
) (
	input  logic             Clock,
	input  logic             rst_n,
	input  logic             key_jump_n,
	input  logic             key_duck_n,
	input  logic             uart_rxd,
	output dino_pkg::seg7_t  hex0,
	output dino_pkg::seg7_t  hex1,
	output dino_pkg::seg7_t  hex2,
	output dino_pkg::seg7_t  hex3,
	output dino_pkg::seg7_t  hex4,
	output dino_pkg::seg7_t  hex5,
	output logic             game_over,
	output logic             ducking,
	output dino_pkg::pos_y_t dino_y,
	output dino_pkg::pos_x_t obstacle_x
);
	logic             rx_valid;
	logic [7:0]       rx_byte;
	logic             jump_cmd;
	logic             duck_cmd;
	logic             respawn;
	dino_pkg::score_t score;
	dino_pkg::score_t high_score;

	uart_rx #(.OS_DIV(OS_DIV)) uart_rx_inst (.Clock(Clock), .rst_n(rst_n), .rxd(uart_rxd),
		.rx_valid(rx_valid), .rx_byte(rx_byte));

	player_command player_command_inst (.Clock(Clock), .rst_n(rst_n),
		.key_jump_n(key_jump_n), .key_duck_n(key_duck_n), .rx_valid(rx_valid),
		.rx_byte(rx_byte), .jump_cmd(jump_cmd), .duck_cmd(duck_cmd));

	dino_motion #(.TICK_CYCLES(TICK_CYCLES)) dino_motion_inst (.Clock(Clock), .rst_n(rst_n),
		.game_over(game_over), .jump_cmd(jump_cmd), .duck_cmd(duck_cmd),
		.dino_y(dino_y), .ducking(ducking));

	obstacle_motion #(.TICK_CYCLES(TICK_CYCLES)) obstacle_motion_inst (.Clock(Clock),
		.rst_n(rst_n), .game_over(game_over), .respawn(respawn), .obstacle_x(obstacle_x));

	score_keeper score_keeper_inst (.Clock(Clock), .rst_n(rst_n), .dino_y(dino_y),
		.obstacle_x(obstacle_x), .game_over(game_over), .respawn(respawn),
		.score(score), .high_score(high_score));

	score_display score_display_inst (.score(score), .high_score(high_score),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5));

endmodule

//--- tests/dino_game_checks.svh
// Serial frame, start bit low, LSB first, one stop bit
task automatic send_uart_byte(input logic [7:0] value);
	logic [9:0] frame;
	frame = {1'b1, value, 1'b0};
	for (int i = 0; i < 10; i++) begin
		@(posedge Clock);
		uart_rxd <= frame[i];
		repeat (BIT_CYCLES - 1) @(posedge Clock);
	end
	repeat (2) @(posedge Clock);   // Short idle gap
endtask

function automatic logic [31:0] xorshift32(input logic [31:0] state);
	logic [31:0] s;
	s = state;
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

// Bit d of each mask is set when the segment lights for digit d
function automatic dino_pkg::seg7_t seg_pattern(input int digit);
	logic [9:0] lit [7];
	dino_pkg::seg7_t pattern;
	lit[0] = 10'b1111101101;   // a
	lit[1] = 10'b1110011111;   // b
	lit[2] = 10'b1111111011;   // c
	lit[3] = 10'b1101101101;   // d
	lit[4] = 10'b0101000101;   // e
	lit[5] = 10'b1101110001;   // f
	lit[6] = 10'b1101111100;   // g
	for (int s = 0; s < 7; s++) begin
		pattern[s] = ~lit[s][digit];   // Active low
	end
	return pattern;
endfunction

task automatic check_pos_y(input dino_pkg::pos_y_t got, input dino_pkg::pos_y_t exp,
	input string what);
	if (got !== exp) begin
		abort_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp));
	end
endtask

task automatic check_pos_x(input dino_pkg::pos_x_t got, input dino_pkg::pos_x_t exp,
	input string what);
	if (got !== exp) begin
		abort_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp));
	end
endtask

task automatic check_seg7(input dino_pkg::seg7_t got, input dino_pkg::seg7_t exp,
	input string what);
	if (got !== exp) begin
		abort_run($sformatf("ERR %0t: %s shows %b, expected %b", $time, what, got, exp));
	end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
	if (got !== exp) begin
		abort_run($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
	end
endtask

//--- tests/dino_game_tb.sv
`timescale 1ns/1ps

module dino_game_tb;
	localparam int TICK_CYCLES = 8;
	localparam int OS_DIV = 2;
	localparam int BIT_CYCLES = 16 * OS_DIV;
	localparam int DINO_TOP_Y = dino_pkg::DINO_GROUND_Y - dino_pkg::JUMP_HEIGHT;

	// Row actions
	localparam int A_NONE = 0, A_RESET = 1, A_UART = 2, A_RAND = 3;
	localparam int A_JKEY = 4, A_DKEY = 5, A_IDLE = 6;
	// What the row waits for and then checks
	localparam int K_Y = 0, K_X = 1, K_DUCK = 2, K_OVER = 3;
	localparam int K_SCORE = 4, K_HIGH = 5, K_RANGE = 6;

	typedef struct packed {
		logic [3:0]  action;
		logic [7:0]  data;
		logic [3:0]  kind;
		logic [15:0] exp_val;
		logic [15:0] budget;   // Cycles allowed for the whole row
	} row_t;

	logic Clock = 1'b0;
	logic rst_n, key_jump_n, key_duck_n, uart_rxd;
	dino_pkg::seg7_t  hex0, hex1, hex2, hex3, hex4, hex5;
	logic             game_over, ducking;
	dino_pkg::pos_y_t dino_y;
	dino_pkg::pos_x_t obstacle_x;

	row_t        stim[$];
	int          cycle_count = 0;
	int          cycle_limit = 0;
	logic [31:0] rng_state = 32'h6640;

	dino_game_top #(.TICK_CYCLES(TICK_CYCLES), .OS_DIV(OS_DIV)) dino_game_top_inst (
		.Clock(Clock), .rst_n(rst_n), .key_jump_n(key_jump_n), .key_duck_n(key_duck_n),
		.uart_rxd(uart_rxd), .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3),
		.hex4(hex4), .hex5(hex5), .game_over(game_over), .ducking(ducking),
		.dino_y(dino_y), .obstacle_x(obstacle_x));

	always #20 Clock = ~Clock;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	`include "dino_game_checks.svh"

	always @(posedge Clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			abort_run($sformatf("Timeout: no verdict after %0d cycles", cycle_limit));
		end
	end

	task automatic add_row(input int action, input int data, input int kind,
		input int exp_val, input int budget);
		stim.push_back('{action[3:0], data[7:0], kind[3:0], exp_val[15:0], budget[15:0]});
	endtask

	task automatic press_key(input logic duck);
		@(posedge Clock);
		if (duck) key_duck_n <= 1'b0;
		else key_jump_n <= 1'b0;
		repeat (4) @(posedge Clock);
		key_duck_n <= 1'b1;
		key_jump_n <= 1'b1;
	endtask

	task automatic do_action(input row_t r);
		logic [7:0] filler;
		case (r.action)
			A_RESET: begin
				@(posedge Clock);
				rst_n <= 1'b0;
				repeat (16) @(posedge Clock);
				rst_n <= 1'b1;
			end
			A_UART: send_uart_byte(r.data);
			A_RAND: begin
				rng_state = xorshift32(rng_state);
				filler = rng_state[7:0];
				if (filler == "J" || filler == "D") filler = filler ^ 8'h01;
				send_uart_byte(filler);
			end
			A_JKEY: press_key(1'b0);
			A_DKEY: press_key(1'b1);
			A_IDLE: repeat (r.data) @(posedge Clock);
			default: ;
		endcase
	endtask

	function automatic logic count_shown(input int value, input logic high);
		if (high) begin
			return hex3 == seg_pattern(value % 10) && hex4 == seg_pattern(value / 10 % 10) &&
				hex5 == seg_pattern(value / 100 % 10);
		end
		return hex0 == seg_pattern(value % 10) && hex1 == seg_pattern(value / 10 % 10) &&
			hex2 == seg_pattern(value / 100 % 10);
	endfunction

	function automatic logic row_met(input row_t r);
		case (r.kind)
			K_Y: return dino_y == r.exp_val[7:0];
			K_X: return obstacle_x == r.exp_val[8:0];
			K_DUCK: return ducking == r.exp_val[0];
			K_OVER: return game_over == r.exp_val[0];
			K_SCORE: return count_shown(r.exp_val, 1'b0);
			K_HIGH: return count_shown(r.exp_val, 1'b1);
			default: return obstacle_x >= 9'd288;   // Respawned
		endcase
	endfunction

	task automatic check_row(input row_t r);
		int v;
		v = r.exp_val;
		case (r.kind)
			K_Y: check_pos_y(dino_y, r.exp_val[7:0], "dino_y");
			K_X: check_pos_x(obstacle_x, r.exp_val[8:0], "obstacle_x");
			K_DUCK: check_flag(ducking, r.exp_val[0], "ducking");
			K_OVER: check_flag(game_over, r.exp_val[0], "game_over");
			K_SCORE: begin
				check_seg7(hex0, seg_pattern(v % 10), "hex0");
				check_seg7(hex1, seg_pattern(v / 10 % 10), "hex1");
				check_seg7(hex2, seg_pattern(v / 100 % 10), "hex2");
			end
			K_HIGH: begin
				check_seg7(hex3, seg_pattern(v % 10), "hex3");
				check_seg7(hex4, seg_pattern(v / 10 % 10), "hex4");
				check_seg7(hex5, seg_pattern(v / 100 % 10), "hex5");
			end
			default: check_flag(obstacle_x >= 9'd288 && obstacle_x <= 9'd387, 1'b1,
				"respawn column in 288 to 387");
		endcase
	endtask

	task automatic load_rows();
		// Reset state and filler bytes that must be ignored
		add_row(A_RESET, 0, K_Y, dino_pkg::DINO_GROUND_Y, 24);
		add_row(A_NONE, 0, K_X, dino_pkg::OBSTACLE_X_INIT, 2);
		add_row(A_NONE, 0, K_OVER, 0, 2);
		add_row(A_NONE, 0, K_DUCK, 0, 2);
		add_row(A_NONE, 0, K_SCORE, 0, 2);
		add_row(A_NONE, 0, K_HIGH, 0, 2);
		add_row(A_RAND, 0, K_Y, dino_pkg::DINO_GROUND_Y, 360);
		add_row(A_RAND, 0, K_Y, dino_pkg::DINO_GROUND_Y, 360);
		add_row(A_NONE, 0, K_DUCK, 0, 2);
		// Serial jump up to the apex and back
		add_row(A_RESET, 0, K_Y, dino_pkg::DINO_GROUND_Y, 24);
		add_row(A_UART, "J", K_Y, DINO_TOP_Y, 900);
		add_row(A_NONE, 0, K_Y, dino_pkg::DINO_GROUND_Y, 600);
		add_row(A_NONE, 0, K_OVER, 0, 2);
		// Duck by byte with a jump ignored meanwhile and then duck by button
		add_row(A_RESET, 0, K_DUCK, 0, 24);
		add_row(A_UART, "D", K_DUCK, 1, 400);
		add_row(A_UART, "J", K_DUCK, 1, 400);
		add_row(A_IDLE, 16, K_Y, dino_pkg::DINO_GROUND_Y, 24);
		add_row(A_NONE, 0, K_DUCK, 0, 800);
		add_row(A_NONE, 0, K_Y, dino_pkg::DINO_GROUND_Y, 2);
		add_row(A_RESET, 0, K_DUCK, 0, 24);
		add_row(A_DKEY, 0, K_DUCK, 1, 12);
		add_row(A_NONE, 0, K_DUCK, 0, 800);
		// Two clean passes with the jump button
		add_row(A_RESET, 0, K_SCORE, 0, 24);
		add_row(A_NONE, 0, K_X, dino_pkg::DINO_X + 50, 2000);
		add_row(A_JKEY, 0, K_SCORE, 1, 500);
		add_row(A_NONE, 0, K_RANGE, 0, 6);
		add_row(A_NONE, 0, K_X, dino_pkg::DINO_X + 50, 2400);
		add_row(A_JKEY, 0, K_SCORE, 2, 500);
		add_row(A_NONE, 0, K_RANGE, 0, 6);
		// Collision freezes everything
		add_row(A_NONE, 0, K_OVER, 1, 2700);
		add_row(A_NONE, 0, K_X, dino_pkg::OBSTACLE_X_INIT, 4);
		add_row(A_NONE, 0, K_Y, dino_pkg::DINO_GROUND_Y, 4);
		add_row(A_IDLE, 64, K_X, dino_pkg::OBSTACLE_X_INIT, 70);
		add_row(A_NONE, 0, K_SCORE, 2, 2);
		add_row(A_NONE, 0, K_OVER, 1, 2);
		// High score kept through reset
		add_row(A_RESET, 0, K_SCORE, 0, 24);
		add_row(A_NONE, 0, K_HIGH, 2, 2);
	endtask

	initial begin
		int total;
		int row_start;
		rst_n = 1'b0;
		key_jump_n = 1'b1;
		key_duck_n = 1'b1;
		uart_rxd = 1'b1;
		load_rows();
		total = 0;
		foreach (stim[i]) total += stim[i].budget;
		cycle_limit = total + total / 4;
		foreach (stim[i]) begin
			row_start = cycle_count;
			do_action(stim[i]);
			@(negedge Clock);
			while (!row_met(stim[i]) && (cycle_count - row_start) < stim[i].budget) begin
				@(negedge Clock);
			end
			check_row(stim[i]);
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

//--- dino_game_top.f
+incdir+tests
source/dino_pkg.sv
source/uart_rx.sv
source/player_command.sv
source/dino_motion.sv
source/obstacle_motion.sv
source/score_keeper.sv
source/score_display.sv
source/dino_game_top.sv
tests/dino_game_tb.sv
